// ==== tb.f ====
common/cart_pkg.sv
loader/ines_header_parser.sv
loader/rom_sequencer.sv
loader/mem_write_port.sv
verilog/cart_loader_top.sv
dv/tb_cart_loader.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the cartridge loader testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

TOP=tb_cart_loader
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module "$TOP" \
	--Mdir "$OBJ_DIR" \
	-o "$TOP" \
	-f tb.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$OBJ_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
	echo "Simulation passed"
	exit 0
fi

echo "Pass line not found in $LOG"
exit 1

// ==== dv/tb_cart_loader.sv ====
// Directed testbench for the cartridge loader
// Host byte driver, memory slot generator, write monitor
// LFSR payload source, header and flag word model, timeout
`timescale 1ns/1ps
`default_nettype none

module tb_cart_loader;

	localparam int ADDR_W = 22;
	localparam logic [ADDR_W-1:0] CHR_BASE = ADDR_W'(1) << (ADDR_W - 1);
	localparam int SLOT_MAX = 7;
	localparam int TOTAL_BYTES = (16 + 24576) + 2 * (16 + 16) + (16 + 16384)
		+ 2 * 16 + (16 + 8192);
	localparam int TIMEOUT_CYCLES = TOTAL_BYTES * SLOT_MAX * 4;

	logic clk;
	logic reset_nes;
	logic download;
	logic byte_valid;
	cart_pkg::byte_t byte_data;
	logic invert_mirroring;
	logic mem_slot = 1'b0;
	logic byte_wait;
	logic mem_write;
	logic [ADDR_W-1:0] mem_addr;
	cart_pkg::byte_t mem_data;
	logic busy;
	logic done;
	logic error;
	cart_pkg::flags_t mapper_flags;

	cart_pkg::byte_t hdr_bytes [16];
	cart_pkg::byte_t sent_q [$];
	logic [ADDR_W-1:0] wr_addr_q [$];
	cart_pkg::byte_t wr_data_q [$];
	logic [15:0] lfsr_state = 16'd34;
	int slot_period = 1;
	int slot_count = 0;
	int cycle_count = 0;
	int error_count = 0;
	int tests_run = 0;
	int tests_failed = 0;
	bit wait_seen = 1'b0;
	bit busy_after_hdr = 1'b0;

	cart_loader_top #(.ADDR_W(ADDR_W)) i_cart_loader_top (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.download         (download),
		.byte_valid       (byte_valid),
		.byte_data        (byte_data),
		.byte_wait        (byte_wait),
		.invert_mirroring (invert_mirroring),
		.mem_slot         (mem_slot),
		.mem_write        (mem_write),
		.mem_addr         (mem_addr),
		.mem_data         (mem_data),
		.busy             (busy),
		.done             (done),
		.error            (error),
		.mapper_flags     (mapper_flags)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////
	// Slots, monitor, timeout
	//////////////////////////////
	always @(negedge clk) begin
		if (slot_count >= slot_period - 1) begin
			slot_count <= 0;
			mem_slot   <= 1'b1;
		end else begin
			slot_count <= slot_count + 1;
			mem_slot   <= 1'b0;
		end
	end

	always @(negedge clk) begin
		if (mem_write) begin   // Registered outputs, stable here
			wr_addr_q.push_back(mem_addr);
			wr_data_q.push_back(mem_data);
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the loader never finished", cycle_count);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic next_random_byte(output cart_pkg::byte_t b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			b = {b[6:0], lfsr_state[0]};   // One LFSR step per bit
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	// Smallest c with 2**c >= pages, capped at 7
	function automatic logic [2:0] size_code_model(input cart_pkg::byte_t pages);
		int c;
		c = 0;
		while (c < 7 && (1 << c) < int'(pages))
			c++;
		return c[2:0];
	endfunction

	function automatic cart_pkg::flags_t model_flags(input logic invert);
		cart_pkg::flags_t f;
		logic nes20;
		logic dirty;
		nes20 = (hdr_bytes[7][3:2] == 2'b10);
		dirty = (hdr_bytes[9][7:1] != 7'd0);
		for (int i = 10; i < 16; i++)
			dirty = dirty | (hdr_bytes[i] != 8'h00);
		dirty = dirty & ~nes20;
		f = '0;
		f[3:0]   = hdr_bytes[6][7:4];
		f[7:4]   = dirty ? 4'h0 : hdr_bytes[7][7:4];
		f[10:8]  = size_code_model(hdr_bytes[4]);
		f[13:11] = size_code_model(hdr_bytes[5]);
		f[14]    = hdr_bytes[6][0] ^ invert;
		f[15]    = (hdr_bytes[5] == 8'h00);
		f[16]    = hdr_bytes[6][3];
		f[24:17] = nes20 ? hdr_bytes[8] : 8'h00;
		f[25]    = hdr_bytes[6][1];
		return f;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		assert (cond) else begin
			$display("%s", what);
			error_count++;
		end
	endtask

	task automatic make_header(input cart_pkg::byte_t prg, input cart_pkg::byte_t chr,
		input cart_pkg::byte_t f6, input cart_pkg::byte_t f7);
		for (int i = 0; i < 16; i++)
			hdr_bytes[i] = 8'h00;
		hdr_bytes[0] = 8'h4E;
		hdr_bytes[1] = 8'h45;
		hdr_bytes[2] = 8'h53;
		hdr_bytes[3] = 8'h1A;
		hdr_bytes[4] = prg;
		hdr_bytes[5] = chr;
		hdr_bytes[6] = f6;
		hdr_bytes[7] = f7;
	endtask

	// Called and returns on a falling edge, leaves a low cycle between bytes
	task automatic send_byte(input cart_pkg::byte_t b);
		bit taken;
		taken = 1'b0;
		byte_valid = 1'b1;
		byte_data  = b;
		while (!taken) begin
			#5;
			if (byte_wait)
				wait_seen = 1'b1;
			else
				taken = 1'b1;
			@(negedge clk);
		end
		byte_valid = 1'b0;
		@(negedge clk);
	endtask

	task automatic load_image(input int n_payload);
		cart_pkg::byte_t b;
		sent_q.delete();
		wr_addr_q.delete();
		wr_data_q.delete();
		download = 1'b1;
		@(negedge clk);
		for (int i = 0; i < 16; i++)
			send_byte(hdr_bytes[i]);
		busy_after_hdr = busy;   // Header taken, loading starts
		for (int i = 0; i < n_payload; i++) begin
			next_random_byte(b);
			sent_q.push_back(b);
			send_byte(b);
		end
		download = 1'b0;
		while (!done)
			@(negedge clk);
		repeat (4 * SLOT_MAX + 8) @(negedge clk);   // Last write leaves the port
	endtask

	task automatic compare_writes(input int prg_bytes, input int n_expected);
		int start_errs;
		logic [ADDR_W-1:0] exp_addr;
		start_errs = error_count;
		check_value("write count", wr_addr_q.size(), n_expected);
		for (int k = 0; k < n_expected && k < wr_addr_q.size(); k++) begin
			if (k < prg_bytes)
				exp_addr = ADDR_W'(k);
			else
				exp_addr = CHR_BASE + ADDR_W'(k - prg_bytes);
			check_value("mem_addr", wr_addr_q[k], exp_addr);
			check_value("mem_data", wr_data_q[k], sent_q[k]);
			if (error_count != start_errs)
				break;   // First mismatch is enough
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (error_count == errs_before) begin
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed, %0d checks", name, error_count - errs_before);
		end
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////
	task automatic test_reset_values();
		int errs;
		errs = error_count;
		check_value("byte_wait", byte_wait, 0);
		check_value("mem_write", mem_write, 0);
		check_value("busy", busy, 0);
		check_value("done", done, 0);
		check_value("error", error, 0);
		report_test("reset values", errs);
	endtask

	task automatic test_full_image();
		int errs;
		errs = error_count;
		slot_period = 1;
		make_header(8'd1, 8'd1, 8'h13, 8'h10);
		load_image(24576);
		compare_writes(16384, 24576);
		check_value("busy", busy_after_hdr, 1);
		check_value("busy", busy, 0);
		check_value("done", done, 1);
		check_value("error", error, 0);
		check_value("mapper_flags", mapper_flags, model_flags(1'b0));
		report_test("full image", errs);
	endtask

	task automatic test_header_checks();
		int errs;
		errs = error_count;
		make_header(8'd1, 8'd0, 8'h00, 8'h00);
		hdr_bytes[1] = 8'h46;   // Broken signature
		load_image(16);
		compare_writes(0, 0);
		check_value("error", error, 1);
		check_value("done", done, 1);
		make_header(8'd1, 8'd0, 8'h04, 8'h00);   // Trainer present
		load_image(16);
		compare_writes(0, 0);
		check_value("error", error, 1);
		check_value("done", done, 1);
		report_test("header checks", errs);
	endtask

	task automatic test_back_pressure();
		int errs;
		errs = error_count;
		slot_period = 7;
		wait_seen = 1'b0;
		make_header(8'd1, 8'd0, 8'h00, 8'h00);
		load_image(16384);
		compare_writes(16384, 16384);
		check_value("error", error, 0);
		check_value("mapper_flags", mapper_flags, model_flags(1'b0));
		check_value("chr_ram flag", mapper_flags[15], 1);
		check_true(wait_seen, "byte_wait never went high while memory slots were scarce");
		slot_period = 1;
		report_test("back-pressure", errs);
	endtask

	task automatic test_flag_decode();
		int errs;
		errs = error_count;
		invert_mirroring = 1'b1;
		make_header(8'd2, 8'd5, 8'h39, 8'h58);   // iNES 2.0
		hdr_bytes[8]  = 8'h27;
		hdr_bytes[12] = 8'h11;
		load_image(0);
		check_value("mapper_flags", mapper_flags, model_flags(1'b1));
		check_value("error", error, 1);   // Header only, pages still due
		invert_mirroring = 1'b0;
		make_header(8'd1, 8'd1, 8'h20, 8'h70);   // Old header with junk tail
		hdr_bytes[8]  = 8'h12;
		hdr_bytes[13] = 8'h44;
		load_image(0);
		check_value("mapper upper nibble", mapper_flags[7:4], 0);
		check_value("mapper_flags", mapper_flags, model_flags(1'b0));
		report_test("flag decode", errs);
	endtask

	task automatic test_truncated_file();
		int errs;
		errs = error_count;
		make_header(8'd1, 8'd1, 8'h00, 8'h00);
		load_image(8192);
		compare_writes(16384, 8192);
		check_value("error", error, 1);
		check_value("done", done, 1);
		report_test("truncated file", errs);
	endtask

	initial begin
		reset_nes        = 1'b1;
		download         = 1'b0;
		byte_valid       = 1'b0;
		byte_data        = 8'h00;
		invert_mirroring = 1'b0;
		repeat (16) @(negedge clk);
		reset_nes = 1'b0;
		@(negedge clk);

		test_reset_values();
		test_full_image();
		test_header_checks();
		test_back_pressure();
		test_flag_decode();
		test_truncated_file();

		$display("tests run %0d, tests failed %0d, checks failed %0d",
			tests_run, tests_failed, error_count);
		if (error_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/cart_loader_top.sv ====
// Cartridge image loader top level
// Parser, sequencer and write port as a three-stage pipeline
`timescale 1ns/1ps
`default_nettype none

module cart_loader_top #(
	parameter int ADDR_W = cart_pkg::ADDR_W_DEFAULT
) (
	input  wire               clk,
	input  wire               reset_nes,
	input  wire               download,
	input  wire               byte_valid,
	input  cart_pkg::byte_t   byte_data,
	output logic              byte_wait,
	input  wire               invert_mirroring,
	input  wire               mem_slot,
	output logic              mem_write,
	output logic [ADDR_W-1:0] mem_addr,
	output cart_pkg::byte_t   mem_data,
	output logic              busy,
	output logic              done,
	output logic              error,
	output cart_pkg::flags_t  mapper_flags
);

	logic parser_ready;
	logic hdr_valid;
	logic hdr_bad;
	cart_pkg::header_info_t hdr;
	logic pay_valid;
	logic pay_ready;
	cart_pkg::payload_t pay;
	logic req_valid;
	logic req_ready;
	cart_pkg::mem_req_t req;

	assign byte_wait = ~parser_ready;   // Host stalls on a full parser

	ines_header_parser i_ines_header_parser (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.download         (download),
		.byte_valid       (byte_valid),
		.byte_data        (byte_data),
		.ready            (parser_ready),
		.invert_mirroring (invert_mirroring),
		.hdr_valid        (hdr_valid),
		.hdr_bad          (hdr_bad),
		.hdr              (hdr),
		.pay_valid        (pay_valid),
		.pay              (pay),
		.pay_ready        (pay_ready)
	);

	rom_sequencer #(.ADDR_W(ADDR_W)) i_rom_sequencer (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.download     (download),
		.hdr_valid    (hdr_valid),
		.hdr_bad      (hdr_bad),
		.hdr          (hdr),
		.pay_valid    (pay_valid),
		.pay          (pay),
		.pay_ready    (pay_ready),
		.req_valid    (req_valid),
		.req          (req),
		.req_ready    (req_ready),
		.busy         (busy),
		.done         (done),
		.error        (error),
		.mapper_flags (mapper_flags)
	);

	mem_write_port #(.ADDR_W(ADDR_W)) i_mem_write_port (
		.clk       (clk),
		.reset_nes (reset_nes),
		.req_valid (req_valid),
		.req       (req),
		.req_ready (req_ready),
		.mem_slot  (mem_slot),
		.mem_write (mem_write),
		.mem_addr  (mem_addr),
		.mem_data  (mem_data)
	);

endmodule

`default_nettype wire

// ==== loader/mem_write_port.sv ====
// Loader stage 3
// One-entry write buffer, issues a write in a granted memory slot
`timescale 1ns/1ps
`default_nettype none

module mem_write_port #(
	parameter int ADDR_W = cart_pkg::ADDR_W_DEFAULT
) (
	input  wire                clk,
	input  wire                reset_nes,
	input  wire                req_valid,
	input  cart_pkg::mem_req_t req,
	output logic               req_ready,
	input  wire                mem_slot,
	output logic               mem_write,
	output logic [ADDR_W-1:0]  mem_addr,
	output cart_pkg::byte_t    mem_data
);

	cart_pkg::mem_req_t held;
	logic held_valid;
	logic issue;

	assign issue     = held_valid & mem_slot;
	assign req_ready = ~held_valid | issue;   // Refill while issuing

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			held_valid <= 1'b0;
			mem_write  <= 1'b0;
		end else begin
			mem_write <= issue;
			if (req_valid && req_ready)
				held_valid <= 1'b1;
			else if (issue)
				held_valid <= 1'b0;
		end
	end

	// Buffer and registered memory outputs
	always_ff @(posedge clk) begin
		if (req_valid && req_ready)
			held <= req;
		if (issue) begin
			mem_addr <= held.addr[ADDR_W-1:0];
			mem_data <= held.data;
		end
	end

	// Host bytes are single-cycle pulses, so writes come at most every other cycle
	a_write_gap: assert property (@(posedge clk) disable iff (reset_nes)
		mem_write |=> !mem_write);

endmodule

`default_nettype wire

// ==== loader/rom_sequencer.sv ====
// Loader stage 2
// Counts program and character bytes, assigns write addresses
// Reports busy, done and error, latches the mapper flags
`timescale 1ns/1ps
`default_nettype none

module rom_sequencer #(
	parameter int ADDR_W = cart_pkg::ADDR_W_DEFAULT
) (
	input  wire                    clk,
	input  wire                    reset_nes,
	input  wire                    download,
	input  wire                    hdr_valid,
	input  wire                    hdr_bad,
	input  cart_pkg::header_info_t hdr,
	input  wire                    pay_valid,
	input  cart_pkg::payload_t     pay,
	output logic                   pay_ready,
	output logic                   req_valid,
	output cart_pkg::mem_req_t     req,
	input  wire                    req_ready,
	output logic                   busy,
	output logic                   done,
	output logic                   error,
	output cart_pkg::flags_t       mapper_flags
);

	localparam int PRG_SHIFT = $clog2(cart_pkg::PRG_PAGE_BYTES);
	localparam int CHR_SHIFT = $clog2(cart_pkg::CHR_PAGE_BYTES);
	localparam int CNT_W     = $bits(cart_pkg::page_count_t) + PRG_SHIFT;
	localparam logic [ADDR_W-1:0] CHR_BASE = {1'b1, {(ADDR_W-1){1'b0}}};

	cart_pkg::seq_state_e state;
	cart_pkg::page_count_t chr_pages;
	logic [ADDR_W-1:0] addr;
	logic [cart_pkg::ADDR_W_DEFAULT-1:0] addr_ext;
	logic [CNT_W-1:0] remain;
	logic dl_q;
	logic dl_rise;
	logic loading;
	logic slot_free;
	logic take;
	logic issue;
	logic hdr_take;

	assign dl_rise   = download & ~dl_q;
	assign loading   = (state == cart_pkg::PRG) | (state == cart_pkg::CHR);
	assign slot_free = ~req_valid | req_ready;
	assign pay_ready = loading ? slot_free : 1'b1;  // Outside a load, bytes are dropped
	assign take      = pay_valid & pay_ready;
	assign issue     = take & ~pay.last & loading & ~dl_rise;
	assign hdr_take  = (state == cart_pkg::IDLE) & hdr_valid & ~dl_rise;
	assign busy      = (state != cart_pkg::IDLE) & ~done;

	always_comb begin
		addr_ext = '0;
		addr_ext[ADDR_W-1:0] = addr;
	end

	//////////////////////////////
	// State machine
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			dl_q         <= 1'b0;
			state        <= cart_pkg::IDLE;
			req_valid    <= 1'b0;
			done         <= 1'b0;
			error        <= 1'b0;
			mapper_flags <= '0;
		end else begin
			dl_q <= download;
			if (req_valid && req_ready)
				req_valid <= 1'b0;
			if (dl_rise) begin
				state <= cart_pkg::IDLE;
				done  <= 1'b0;
				error <= 1'b0;
			end else begin
				case (state)
				cart_pkg::IDLE:
					if (hdr_valid) begin
						mapper_flags <= hdr.flags;
						if (hdr_bad) begin
							state <= cart_pkg::ERROR;
							error <= 1'b1;
							done  <= 1'b1;
						end else if (hdr.prg_pages != '0)
							state <= cart_pkg::PRG;
						else if (hdr.chr_pages != '0)
							state <= cart_pkg::CHR;
						else
							state <= cart_pkg::DONE;
					end else if (take && pay.last) begin
						state <= cart_pkg::ERROR;   // File ended inside the header
						error <= 1'b1;
						done  <= 1'b1;
					end
				cart_pkg::PRG, cart_pkg::CHR:
					if (take && pay.last) begin
						state <= cart_pkg::ERROR;   // Bytes still due
						error <= 1'b1;
						done  <= 1'b1;
					end else if (take) begin
						req_valid <= 1'b1;
						if (remain == CNT_W'(1)) begin
							if (state == cart_pkg::PRG && chr_pages != '0)
								state <= cart_pkg::CHR;
							else
								state <= cart_pkg::DONE;
						end
					end
				cart_pkg::DONE:
					if (slot_free)
						done <= 1'b1;   // Last write has left for the port
				default: ;
				endcase
			end
		end
	end

	// Address and byte counters
	always_ff @(posedge clk) begin
		if (hdr_take) begin
			chr_pages <= hdr.chr_pages;
			if (hdr.prg_pages != '0) begin
				addr   <= '0;
				remain <= CNT_W'(hdr.prg_pages) << PRG_SHIFT;
			end else begin
				addr   <= CHR_BASE;
				remain <= CNT_W'(hdr.chr_pages) << CHR_SHIFT;
			end
		end else if (issue) begin
			if (remain == CNT_W'(1) && state == cart_pkg::PRG) begin
				addr   <= CHR_BASE;
				remain <= CNT_W'(chr_pages) << CHR_SHIFT;
			end else begin
				addr   <= addr + 1'b1;
				remain <= remain - 1'b1;
			end
		end
		if (issue) begin
			req.addr <= addr_ext;
			req.data <= pay.data;
		end
	end

	a_done_error: assert property (@(posedge clk) disable iff (reset_nes)
		(done && error) |-> (state == cart_pkg::ERROR));

endmodule

`default_nettype wire

// ==== loader/ines_header_parser.sv ====
// Loader stage 1
// Collects the 16 header bytes, checks and decodes them
// Forwards payload bytes and an end-of-file marker
`timescale 1ns/1ps
`default_nettype none

module ines_header_parser (
	input  wire                    clk,
	input  wire                    reset_nes,
	input  wire                    download,
	input  wire                    byte_valid,
	input  cart_pkg::byte_t        byte_data,
	output logic                   ready,
	input  wire                    invert_mirroring,
	output logic                   hdr_valid,
	output logic                   hdr_bad,
	output cart_pkg::header_info_t hdr,
	output logic                   pay_valid,
	output cart_pkg::payload_t     pay,
	input  wire                    pay_ready
);

	localparam int CNT_W = $clog2(cart_pkg::HDR_LEN + 1);

	cart_pkg::byte_t ines [0:cart_pkg::HDR_LEN-1];
	logic [CNT_W-1:0] hdr_cnt;
	logic [CNT_W-1:0] cnt_cur;
	logic dl_q;
	logic dl_rise;
	logic dl_fall;
	logic eof_pend;
	logic accept;
	logic hdr_full;
	logic eof_load;
	logic hdr_seen;
	logic is_nes20;
	logic is_dirty;
	logic tail_nz;
	cart_pkg::byte_t mapper;
	cart_pkg::flags_t flags;

	assign dl_rise  = download & ~dl_q;
	assign dl_fall  = ~download & dl_q;
	assign ready    = ~pay_valid | pay_ready;   // Slot empty or draining
	assign accept   = byte_valid & ready;
	assign cnt_cur  = dl_rise ? '0 : hdr_cnt;  // Restart counts from byte 0
	assign hdr_full = (cnt_cur == CNT_W'(cart_pkg::HDR_LEN));
	assign eof_load = eof_pend & ready & ~accept & ~dl_rise;

	//////////////////////////////
	// Control
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			dl_q      <= 1'b0;
			hdr_cnt   <= '0;
			hdr_valid <= 1'b0;
			pay_valid <= 1'b0;
			eof_pend  <= 1'b0;
		end else begin
			dl_q      <= download;
			hdr_valid <= 1'b0;
			if (pay_valid && pay_ready)
				pay_valid <= 1'b0;
			if (dl_rise) begin
				hdr_cnt   <= '0;
				eof_pend  <= 1'b0;
				pay_valid <= 1'b0;   // Drop leftovers of an old file
			end
			if (dl_fall)
				eof_pend <= 1'b1;
			if (accept) begin
				if (!hdr_full) begin
					hdr_cnt <= cnt_cur + 1'b1;
					if (cnt_cur == CNT_W'(cart_pkg::HDR_LEN - 1))
						hdr_valid <= 1'b1;
				end else begin
					pay_valid <= 1'b1;
				end
			end else if (eof_load) begin
				pay_valid <= 1'b1;
				eof_pend  <= 1'b0;
			end
		end
	end

	// Header bytes and payload slot
	always_ff @(posedge clk) begin
		if (accept && !hdr_full)
			ines[cnt_cur[3:0]] <= byte_data;
		if (accept && hdr_full) begin
			pay.data <= byte_data;
			pay.last <= 1'b0;
		end else if (eof_load) begin
			pay.data <= '0;
			pay.last <= 1'b1;
		end
	end

	//////////////////////////////
	// Header decode
	//////////////////////////////
	always_comb begin
		tail_nz = |ines[9][7:1];
		for (int i = 10; i < cart_pkg::HDR_LEN; i++)
			tail_nz = tail_nz | (|ines[i]);
		is_nes20 = (ines[7][3:2] == 2'b10);
		is_dirty = ~is_nes20 & tail_nz;   // Junk in bytes 9..15 of an old header
		mapper   = {is_dirty ? 4'h0 : ines[7][7:4], ines[6][7:4]};

		flags = '0;
		flags[cart_pkg::FLG_MAPPER_LSB +: $bits(cart_pkg::byte_t)] = mapper;
		flags[cart_pkg::FLG_PRG_SIZE_LSB +: $bits(cart_pkg::size_code_t)] =
			cart_pkg::size_code(ines[4]);
		flags[cart_pkg::FLG_CHR_SIZE_LSB +: $bits(cart_pkg::size_code_t)] =
			cart_pkg::size_code(ines[5]);
		flags[cart_pkg::FLG_MIRROR]      = ines[6][0] ^ invert_mirroring;
		flags[cart_pkg::FLG_CHR_RAM]     = (ines[5] == 8'h00);
		flags[cart_pkg::FLG_FOUR_SCREEN] = ines[6][3];
		flags[cart_pkg::FLG_SUBMAPPER_LSB +: $bits(cart_pkg::byte_t)] =
			is_nes20 ? ines[8] : 8'h00;
		flags[cart_pkg::FLG_HAS_SAVES]   = ines[6][1];

		hdr.prg_pages = ines[4];
		hdr.chr_pages = ines[5];
		hdr.flags     = flags;

		// Trainers are not supported
		hdr_bad = ({ines[0], ines[1], ines[2], ines[3]} != cart_pkg::INES_MAGIC)
			| ines[6][2];
	end

	// One header per file
	always_ff @(posedge clk) begin
		if (reset_nes || dl_rise)
			hdr_seen <= 1'b0;
		else if (hdr_valid)
			hdr_seen <= 1'b1;
	end

	a_one_header: assert property (@(posedge clk) disable iff (reset_nes)
		hdr_valid |-> !hdr_seen);

endmodule

`default_nettype wire

// ==== common/cart_pkg.sv ====
// Shared types and constants for the cartridge loader
// Header, payload and memory request structs, flag word layout
// Size code helper and sequencer state enum
`default_nettype none

package cart_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [7:0] page_count_t;
	typedef logic [2:0] size_code_t;
	typedef logic [31:0] flags_t;

	localparam int HDR_LEN        = 16;
	localparam int PRG_PAGE_BYTES = 16384;
	localparam int CHR_PAGE_BYTES = 8192;
	localparam int ADDR_W_DEFAULT = 22;

	localparam logic [31:0] INES_MAGIC = 32'h4E45_531A; // "NES" + EOF

	//////////////////////////////
	// Mapper flag word layout
	//////////////////////////////
	localparam int FLG_MAPPER_LSB    = 0;   // 8 bits
	localparam int FLG_PRG_SIZE_LSB  = 8;   // 3 bits
	localparam int FLG_CHR_SIZE_LSB  = 11;  // 3 bits
	localparam int FLG_MIRROR        = 14;
	localparam int FLG_CHR_RAM       = 15;
	localparam int FLG_FOUR_SCREEN   = 16;
	localparam int FLG_SUBMAPPER_LSB = 17;  // 8 bits, iNES 2.0 only
	localparam int FLG_HAS_SAVES     = 25;  // Bits above stay zero

	typedef struct packed {
		page_count_t prg_pages;
		page_count_t chr_pages;
		flags_t      flags;
	} header_info_t;

	typedef struct packed {
		byte_t data;
		logic  last;   // End-of-file marker, data unused
	} payload_t;

	typedef struct packed {
		logic [ADDR_W_DEFAULT-1:0] addr;
		byte_t                     data;
	} mem_req_t;

	typedef enum logic [2:0] {
		IDLE,
		PRG,
		CHR,
		DONE,
		ERROR
	} seq_state_e;

	// Ceiling log2 of page count, saturating at 7
	function automatic size_code_t size_code(page_count_t pages);
		size_code_t code;
		code = 3'd7;
		for (int i = 6; i >= 0; i--) begin
			if (pages <= (page_count_t'(1) << i))
				code = size_code_t'(i);
		end
		return code;
	endfunction

endpackage

`default_nettype wire
